//--- source/cnn_load_pkg.sv
package cnn_load_pkg;

    ///////////////////////////////
    // Buffer geometry
    ///////////////////////////////
    localparam int DATA_WIDTH = 16;     // One fp16 value per word
    localparam int BUF_DEPTH  = 64;
    localparam int ADDR_WIDTH = 6;

    // Feature-map region, words 0 to 17
    localparam logic [ADDR_WIDTH-1:0] FM_BASE  = 6'd0;
    localparam logic [ADDR_WIDTH-1:0] FM_WORDS = 6'd18;

    // Weight region, two 3x3 slots per half
    localparam logic [ADDR_WIDTH-1:0] WT_BASE      = 6'd24;
    localparam logic [ADDR_WIDTH-1:0] KERNEL_WORDS = 6'd9;
    localparam logic [ADDR_WIDTH-1:0] WT_HALF      = 6'd20;
    localparam int                    NUM_SLOTS    = 4;
    localparam int                    SLOT_WIDTH   = 2;

    localparam logic [DATA_WIDTH-1:0] FILL_DEFAULT = 16'h3c00; // fp16 one

    ///////////////////////////////
    // APB register map
    ///////////////////////////////
    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL       = 12'h000;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_FILL       = 12'h004;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SLOT       = 12'h008;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS     = 12'h00c;
    localparam logic [APB_ADDR_WIDTH-1:0] BUF_WINDOW     = 12'h100;
    localparam logic [APB_ADDR_WIDTH-1:0] BUF_WINDOW_END = 12'h200; // One past word 63

    // Arbiter requester indices
    localparam int NUM_REQ       = 3;
    localparam int REQ_IDX_WIDTH = 2;
    localparam int REQ_HOST      = 0;
    localparam int REQ_FM        = 1;
    localparam int REQ_WT        = 2;

endpackage

//--- source/tile_buffer.sv
module tile_buffer (
    input  logic                                clk,
    input  logic                                mem_en,
    input  logic                                mem_we,
    input  logic [cnn_load_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  logic [cnn_load_pkg::DATA_WIDTH-1:0] mem_wdata,
    output logic [cnn_load_pkg::DATA_WIDTH-1:0] mem_rdata
);
    import cnn_load_pkg::*;

    logic [DATA_WIDTH-1:0] mem [BUF_DEPTH];

    // Single port, read data lands one cycle after the enabled read
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule

//--- source/buf_arbiter.sv
module buf_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cnn_load_pkg::NUM_REQ-1:0]    req,
    output logic [cnn_load_pkg::NUM_REQ-1:0]    gnt,
    input  logic                                host_we,
    input  logic [cnn_load_pkg::ADDR_WIDTH-1:0] host_addr,
    input  logic [cnn_load_pkg::DATA_WIDTH-1:0] host_wdata,
    input  logic [cnn_load_pkg::ADDR_WIDTH-1:0] fm_addr,
    input  logic [cnn_load_pkg::DATA_WIDTH-1:0] fm_wdata,
    input  logic [cnn_load_pkg::ADDR_WIDTH-1:0] wt_addr,
    input  logic [cnn_load_pkg::DATA_WIDTH-1:0] wt_wdata,
    output logic                                mem_en,
    output logic                                mem_we,
    output logic [cnn_load_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [cnn_load_pkg::DATA_WIDTH-1:0] mem_wdata
);
    import cnn_load_pkg::*;

    logic [REQ_IDX_WIDTH-1:0] last_win;
    logic [REQ_IDX_WIDTH-1:0] win_idx;

    // Search starts one past the last winner
    always_comb begin
        int  cand;
        logic found;
        gnt     = '0;
        win_idx = last_win;
        found   = 1'b0;
        for (int i = 1; i <= NUM_REQ; i++) begin
            cand = int'(last_win) + i;
            if (cand >= NUM_REQ) cand = cand - NUM_REQ; // Wrap
            if (!found && req[cand]) begin
                gnt[cand] = 1'b1;
                win_idx   = REQ_IDX_WIDTH'(cand);
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_win <= REQ_IDX_WIDTH'(NUM_REQ - 1); // Host first after reset
        end else if (|gnt) begin
            last_win <= win_idx;
        end
    end

    // Port mux, writer grants are always writes
    always_comb begin
        mem_en    = |gnt;
        mem_we    = 1'b1;
        mem_addr  = host_addr;
        mem_wdata = host_wdata;
        if (gnt[REQ_FM]) begin
            mem_addr  = fm_addr;
            mem_wdata = fm_wdata;
        end else if (gnt[REQ_WT]) begin
            mem_addr  = wt_addr;
            mem_wdata = wt_wdata;
        end else if (gnt[REQ_HOST]) begin
            mem_we = host_we;
        end
    end

endmodule

//--- source/fm_init_writer.sv
module fm_init_writer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                init_pulse,
    input  logic [cnn_load_pkg::DATA_WIDTH-1:0] fill_value,
    output logic                                fm_busy,
    output logic                                fm_req,
    output logic [cnn_load_pkg::ADDR_WIDTH-1:0] fm_addr,
    output logic [cnn_load_pkg::DATA_WIDTH-1:0] fm_wdata,
    input  logic                                fm_gnt
);
    import cnn_load_pkg::*;

    logic [ADDR_WIDTH-1:0] word_cnt;
    logic [DATA_WIDTH-1:0] fill_q;

    // One request per word while the walk is active
    assign fm_req   = fm_busy;
    assign fm_addr  = FM_BASE + word_cnt;
    assign fm_wdata = fill_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            fm_busy  <= 1'b0;
            word_cnt <= '0;
        end else if (init_pulse && !fm_busy) begin
            fm_busy  <= 1'b1;
            word_cnt <= '0;
        end else if (fm_busy && fm_gnt) begin
            if (word_cnt == FM_WORDS - 1'b1) begin
                fm_busy  <= 1'b0; // Last word written
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // Fill value captured with the command
    always_ff @(posedge clk) begin
        if (init_pulse && !fm_busy) begin
            fill_q <= fill_value;
        end
    end

endmodule

//--- source/weight_writer.sv
module weight_writer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                init_pulse,
    input  logic                                update_pulse,
    input  logic [cnn_load_pkg::SLOT_WIDTH-1:0] upd_slot,
    input  logic [cnn_load_pkg::DATA_WIDTH-1:0] fill_value,
    output logic                                wt_busy,
    output logic                                wt_req,
    output logic [cnn_load_pkg::ADDR_WIDTH-1:0] wt_addr,
    output logic [cnn_load_pkg::DATA_WIDTH-1:0] wt_wdata,
    input  logic                                wt_gnt
);
    import cnn_load_pkg::*;

    logic [SLOT_WIDTH-1:0] slot_cnt;
    logic [ADDR_WIDTH-1:0] word_cnt;  // Word inside the kernel
    logic [ADDR_WIDTH-1:0] slot_base;
    logic                  walk_all;  // Init covers every slot
    logic [DATA_WIDTH-1:0] fill_q;
    logic                  cmd_take;

    // Odd slots sit one kernel up, upper slots in the second half
    assign slot_base = WT_BASE + (slot_cnt[1] ? WT_HALF : '0) + (slot_cnt[0] ? KERNEL_WORDS : '0);

    assign wt_req   = wt_busy;
    assign wt_addr  = slot_base + word_cnt;
    assign wt_wdata = fill_q;
    assign cmd_take = (init_pulse || update_pulse) && !wt_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wt_busy  <= 1'b0;
            walk_all <= 1'b0;
            slot_cnt <= '0;
            word_cnt <= '0;
        end else if (cmd_take) begin
            wt_busy  <= 1'b1;
            walk_all <= init_pulse;                    // Init wins over update
            slot_cnt <= init_pulse ? '0 : upd_slot;
            word_cnt <= '0;
        end else if (wt_busy && wt_gnt) begin
            if (word_cnt == KERNEL_WORDS - 1'b1) begin
                word_cnt <= '0;
                if (!walk_all || slot_cnt == SLOT_WIDTH'(NUM_SLOTS - 1)) begin
                    wt_busy <= 1'b0;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            fill_q <= fill_value;
        end
    end

endmodule

//--- source/apb_load_regs.sv
module apb_load_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [cnn_load_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [cnn_load_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [cnn_load_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    init_pulse,
    output logic                                    update_pulse,
    output logic [cnn_load_pkg::DATA_WIDTH-1:0]     fill_value,
    output logic [cnn_load_pkg::SLOT_WIDTH-1:0]     upd_slot,
    output logic                                    start,
    output logic                                    host_req,
    output logic                                    host_we,
    output logic [cnn_load_pkg::ADDR_WIDTH-1:0]     host_addr,
    output logic [cnn_load_pkg::DATA_WIDTH-1:0]     host_wdata,
    input  logic                                    host_gnt,
    input  logic [cnn_load_pkg::DATA_WIDTH-1:0]     host_rdata,
    input  logic                                    fm_busy,
    input  logic                                    wt_busy
);
    import cnn_load_pkg::*;

    typedef enum logic [1:0] {WIN_IDLE, WIN_WAIT, WIN_RDATA} win_state_t;

    win_state_t win_state;
    logic       access;
    logic       is_reg;
    logic       is_win;
    logic       reg_wr;
    logic       init_armed; // Init issued, waiting for both writers to finish

    assign access = psel && penable;
    assign is_reg = (paddr == REG_CTRL) || (paddr == REG_FILL) ||
                    (paddr == REG_SLOT) || (paddr == REG_STATUS);
    assign is_win = (paddr >= BUF_WINDOW) && (paddr < BUF_WINDOW_END) && (paddr[1:0] == 2'b00);
    assign reg_wr = access && pwrite && is_reg;

    // Window request follows the held APB address phase
    assign host_req   = (win_state == WIN_WAIT);
    assign host_we    = pwrite;
    assign host_addr  = paddr[ADDR_WIDTH+1:2];
    assign host_wdata = pwdata[DATA_WIDTH-1:0];

    assign pslverr = access && !is_reg && !is_win;
    assign pready  = access && (is_reg || !is_win ||
                     (win_state == WIN_WAIT && host_gnt && pwrite) || win_state == WIN_RDATA);

    always_comb begin
        prdata = '0;
        if (win_state == WIN_RDATA) begin
            prdata[DATA_WIDTH-1:0] = host_rdata; // Registered buffer output
        end else if (paddr == REG_FILL) begin
            prdata[DATA_WIDTH-1:0] = fill_value;
        end else if (paddr == REG_SLOT) begin
            prdata[SLOT_WIDTH-1:0] = upd_slot;
        end else if (paddr == REG_STATUS) begin
            prdata[2:0] = {start, wt_busy, fm_busy};
        end
    end

    ///////////////////////////////
    // Window FSM
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            win_state <= WIN_IDLE;
        end else begin
            case (win_state)
                WIN_IDLE:  if (access && is_win) win_state <= WIN_WAIT;
                WIN_WAIT:  if (host_gnt) win_state <= pwrite ? WIN_IDLE : WIN_RDATA;
                default:   win_state <= WIN_IDLE;
            endcase
        end
    end

    ///////////////////////////////
    // Registers and commands
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_value   <= FILL_DEFAULT;
            upd_slot     <= '0;
            init_pulse   <= 1'b0;
            update_pulse <= 1'b0;
        end else begin
            init_pulse   <= reg_wr && (paddr == REG_CTRL) && pwdata[0] && !fm_busy && !wt_busy;
            update_pulse <= reg_wr && (paddr == REG_CTRL) && pwdata[1] && !wt_busy;
            if (reg_wr && paddr == REG_FILL) fill_value <= pwdata[DATA_WIDTH-1:0];
            if (reg_wr && paddr == REG_SLOT) upd_slot <= pwdata[SLOT_WIDTH-1:0];
        end
    end

    // Busy flags rise the cycle after the pulse, so arming waits one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            start      <= 1'b0;
            init_armed <= 1'b0;
        end else if (init_pulse) begin
            start      <= 1'b0;
            init_armed <= 1'b1;
        end else if (init_armed && !fm_busy && !wt_busy) begin
            start      <= 1'b1;
            init_armed <= 1'b0;
        end
    end

endmodule

//--- source/cnn_load_top.sv
module cnn_load_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [cnn_load_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [cnn_load_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [cnn_load_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    start    // To the compute engine
);
    import cnn_load_pkg::*;

    ///////////////////////////////
    // Interconnect
    ///////////////////////////////
    logic                  init_pulse;
    logic                  update_pulse;
    logic [DATA_WIDTH-1:0] fill_value;
    logic [SLOT_WIDTH-1:0] upd_slot;
    logic                  fm_busy;
    logic                  wt_busy;
    logic [NUM_REQ-1:0]    req_vec;
    logic [NUM_REQ-1:0]    gnt_vec;
    logic                  host_we;
    logic [ADDR_WIDTH-1:0] host_addr;
    logic [DATA_WIDTH-1:0] host_wdata;
    logic [ADDR_WIDTH-1:0] fm_addr;
    logic [DATA_WIDTH-1:0] fm_wdata;
    logic [ADDR_WIDTH-1:0] wt_addr;
    logic [DATA_WIDTH-1:0] wt_wdata;
    logic                  mem_en;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic [DATA_WIDTH-1:0] mem_rdata;

    apb_load_regs u_regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .init_pulse(init_pulse), .update_pulse(update_pulse),
        .fill_value(fill_value), .upd_slot(upd_slot), .start(start),
        .host_req(req_vec[REQ_HOST]), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_gnt(gnt_vec[REQ_HOST]), .host_rdata(mem_rdata),
        .fm_busy(fm_busy), .wt_busy(wt_busy)
    );

    fm_init_writer u_fm_writer (
        .clk(clk), .rst(rst), .init_pulse(init_pulse), .fill_value(fill_value),
        .fm_busy(fm_busy), .fm_req(req_vec[REQ_FM]), .fm_addr(fm_addr),
        .fm_wdata(fm_wdata), .fm_gnt(gnt_vec[REQ_FM])
    );

    weight_writer u_wt_writer (
        .clk(clk), .rst(rst), .init_pulse(init_pulse), .update_pulse(update_pulse),
        .upd_slot(upd_slot), .fill_value(fill_value), .wt_busy(wt_busy),
        .wt_req(req_vec[REQ_WT]), .wt_addr(wt_addr), .wt_wdata(wt_wdata),
        .wt_gnt(gnt_vec[REQ_WT])
    );

    buf_arbiter u_arbiter (
        .clk(clk), .rst(rst), .req(req_vec), .gnt(gnt_vec),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .fm_addr(fm_addr), .fm_wdata(fm_wdata), .wt_addr(wt_addr), .wt_wdata(wt_wdata),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    tile_buffer u_buffer (
        .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

//--- dv/tb_cnn_load.sv
module tb_cnn_load;
    import cnn_load_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          SAMPLE_DLY = CLK_PERIOD / 4; // Mid second half, outputs settled
    localparam logic [31:0] SEED       = 32'hd038_b52b;

    // Nine full-buffer passes plus polls and register traffic, rounded up
    localparam int NUM_OPS         = 12 * BUF_DEPTH;
    localparam int OP_CYCLES       = 12;          // Worst APB access under contention
    localparam int WATCHDOG_CYCLES = NUM_OPS * OP_CYCLES;

    typedef enum int {OP_HOST_WR, OP_INIT, OP_UPDATE} op_t;
    typedef logic [BUF_DEPTH-1:0][DATA_WIDTH-1:0] image_t;

    logic                      clk;
    logic                      rst;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      start;

    image_t model;  // Expected buffer image

    cnn_load_top u_dut (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .start(start)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////
    // Reference model
    ////////////////////////////////
    function automatic int slot_base(input int slot);
        return int'(WT_BASE) + (slot / 2) * int'(WT_HALF) + (slot % 2) * int'(KERNEL_WORDS);
    endfunction

    function automatic bit is_fill_word(input int addr);
        bit hit;
        hit = (addr >= int'(FM_BASE)) && (addr < int'(FM_BASE) + int'(FM_WORDS));
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (addr >= slot_base(s) && addr < slot_base(s) + int'(KERNEL_WORDS)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic image_t ref_apply(input image_t img, input op_t op, input int addr,
                                         input logic [DATA_WIDTH-1:0] data,
                                         input logic [DATA_WIDTH-1:0] fill, input int slot);
        image_t res;
        int     base;
        res = img;
        case (op)
            OP_HOST_WR: begin
                res[addr] = data;
            end
            OP_INIT: begin
                for (int i = 0; i < int'(FM_WORDS); i++) begin
                    res[int'(FM_BASE) + i] = fill;
                end
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    base = slot_base(s);
                    for (int k = 0; k < int'(KERNEL_WORDS); k++) begin
                        res[base + k] = fill;
                    end
                end
            end
            default: begin  // Update touches one slot only
                base = slot_base(slot);
                for (int k = 0; k < int'(KERNEL_WORDS); k++) begin
                    res[base + k] = fill;
                end
            end
        endcase
        return res;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] new_sentinel();
        return {1'b1, 15'($urandom)};  // Top bit set, never equal to a fill
    endfunction

    function automatic logic [DATA_WIDTH-1:0] new_fill();
        return {1'b0, 15'($urandom)};
    endfunction

    function automatic int pick_free_word();
        int w;
        w = int'($urandom_range(BUF_DEPTH - 1, 0));
        while (is_fill_word(w)) begin
            w = int'($urandom_range(BUF_DEPTH - 1, 0));
        end
        return w;
    endfunction

    function automatic logic [APB_ADDR_WIDTH-1:0] word_addr(input int w);
        return APB_ADDR_WIDTH'(int'(BUF_WINDOW) + 4 * w);
    endfunction

    function automatic bit in_window(input logic [APB_ADDR_WIDTH-1:0] addr);
        return (addr >= BUF_WINDOW) && (addr < BUF_WINDOW_END) && (addr[1:0] == 2'b00);
    endfunction

    ////////////////////////////////
    // Checks and APB tasks
    ////////////////////////////////
    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("tests failed");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    task automatic transfer(input logic wr, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] wdata,
                            output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(SAMPLE_DLY);
        while (!pready) begin
            @(negedge clk);
            #(SAMPLE_DLY);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);  // Transfer closed by the posedge just passed
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        transfer(1'b1, addr, data, rdata, err);
        compare("pslverr", 32'(err), 32'd0);
    endtask

    task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        logic err;
        transfer(1'b0, addr, '0, data, err);
        compare("pslverr", 32'(err), 32'd0);
    endtask

    task automatic word_write(input int w, input logic [DATA_WIDTH-1:0] data);
        apb_write(word_addr(w), 32'(data));
        model = ref_apply(model, OP_HOST_WR, w, data, '0, 0);
    endtask

    // Data is checked by the read monitor
    task automatic word_read(input int w);
        logic [31:0] data;
        apb_read(word_addr(w), data);
    endtask

    task automatic read_back_all();
        for (int w = 0; w < BUF_DEPTH; w++) begin
            word_read(w);
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        apb_read(REG_STATUS, st);
        while (st[1:0] != 2'b00) begin
            apb_read(REG_STATUS, st);
        end
    endtask

    task automatic run_init(input logic [DATA_WIDTH-1:0] fill);
        apb_write(REG_CTRL, 32'h1);
        model = ref_apply(model, OP_INIT, 0, '0, fill, 0);
    endtask

    task automatic run_update(input int slot, input logic [DATA_WIDTH-1:0] fill);
        apb_write(REG_FILL, 32'(fill));
        apb_write(REG_SLOT, 32'(slot));
        apb_write(REG_CTRL, 32'h2);
        model = ref_apply(model, OP_UPDATE, 0, '0, fill, slot);
    endtask

    // Compares every completed window read against the model
    always @(negedge clk) begin
        int idx;
        #(SAMPLE_DLY);
        if (psel && penable && pready && !pwrite && in_window(paddr)) begin
            idx = (int'(paddr) - int'(BUF_WINDOW)) / 4;
            compare($sformatf("prdata buf[%0d]", idx), prdata, 32'(model[idx]));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////
    initial begin
        logic [31:0]           rd;
        logic                  err;
        logic [DATA_WIDTH-1:0] fill;
        logic [DATA_WIDTH-1:0] late_fill;
        int                    w;
        void'($urandom(SEED));
        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        model   = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Reset values
        apb_read(REG_STATUS, rd);
        compare("status", rd, 32'h0);
        apb_read(REG_FILL, rd);
        compare("fill", rd, 32'(FILL_DEFAULT));
        compare("start", 32'(start), 32'd0);

        // Sentinels everywhere, then init with the default fill
        for (int i = 0; i < BUF_DEPTH; i++) begin
            word_write(i, new_sentinel());
        end
        read_back_all();
        run_init(FILL_DEFAULT);
        wait_idle();
        apb_read(REG_STATUS, rd);
        compare("status", rd, 32'h4);
        compare("start", 32'(start), 32'd1);
        read_back_all();

        // One update per slot, start stays up
        for (int s = 0; s < NUM_SLOTS; s++) begin
            run_update(s, new_fill());
            wait_idle();
            apb_read(REG_STATUS, rd);
            compare("status", rd, 32'h4);
            compare("start", 32'(start), 32'd1);
            read_back_all();
        end

        // Host window traffic while both writers run
        fill = new_fill();
        apb_write(REG_FILL, 32'(fill));
        run_init(fill);
        repeat (8) begin
            w = pick_free_word();
            word_write(w, new_sentinel());
            word_read(w);
        end
        wait_idle();
        apb_read(REG_STATUS, rd);
        compare("status", rd, 32'h4);
        read_back_all();

        // Second init while busy is dropped
        fill = new_fill();
        apb_write(REG_FILL, 32'(fill));
        run_init(fill);
        apb_read(REG_STATUS, rd);
        compare("status", rd, 32'h3);  // Both busy, start cleared
        compare("start", 32'(start), 32'd0);
        late_fill = new_fill();
        apb_write(REG_FILL, 32'(late_fill));
        apb_write(REG_CTRL, 32'h1);
        wait_idle();
        apb_read(REG_STATUS, rd);
        compare("status", rd, 32'h4);
        read_back_all();
        apb_read(REG_FILL, rd);
        compare("fill", rd, 32'(late_fill));

        // Unmapped and misaligned addresses
        transfer(1'b0, 12'h010, '0, rd, err);
        compare("pslverr", 32'(err), 32'd1);
        transfer(1'b1, BUF_WINDOW_END, 32'h1234, rd, err);
        compare("pslverr", 32'(err), 32'd1);
        transfer(1'b0, 12'h102, '0, rd, err);
        compare("pslverr", 32'(err), 32'd1);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- sim.f
source/cnn_load_pkg.sv
source/tile_buffer.sv
source/buf_arbiter.sv
source/fm_init_writer.sv
source/weight_writer.sv
source/apb_load_regs.sv
source/cnn_load_top.sv
dv/tb_cnn_load.sv

//--- Makefile
TOP := tb_cnn_load

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
